// File: src.f
verilog/isa_pkg.sv
verilog/flow_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/op_decoder.sv
verilog/op_queue.sv
verilog/execute_unit.sv
verilog/datapath_top.sv
tb/datapath_tb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - verilog/isa_pkg.sv
  - verilog/flow_pkg.sv
  - verilog/register_file.sv
  - verilog/alu.sv
  - verilog/op_decoder.sv
  - verilog/op_queue.sv
  - verilog/execute_unit.sv
  - verilog/datapath_top.sv
  - target: simulation
    files:
      - tb/datapath_tb.sv

// File: tb/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb import isa_pkg::*; ();

	localparam int n_instr = 230;      // Upper bound over all phases
	localparam int limit_cycles = n_instr * 20 + 1000;

	logic clk;
	logic reset;
	logic in_valid;
	logic [data_w-1:0] in_instr;
	logic in_ready;
	logic res_ready;
	logic res_valid;
	logic [reg_idx_w-1:0] res_dest;
	logic [2*data_w-1:0] res_z;

	logic [data_w-1:0] model_regs [reg_count];
	logic [2*data_w-1:0] model_hilo;
	logic [reg_idx_w+2*data_w-1:0] expected_q [$];    // {dest, z}
	int errors = 0;
	int ready_mode;    // 0 always ready, 1 random, 2 held low
	logic saw_full = 1'b0;

	opcode_t reg_ops [6] = '{op_add, op_sub, op_and, op_or, op_neg, op_not};
	opcode_t imm_ops [3] = '{op_addi, op_andi, op_ori};
	opcode_t shift_ops [4] = '{op_shr, op_shl, op_ror, op_rol};
	opcode_t all_ops [14] = '{op_add, op_sub, op_and, op_or, op_shr, op_shl, op_ror,
		op_rol, op_addi, op_andi, op_ori, op_mul, op_neg, op_not};
	logic [imm_w-1:0] shift_amounts [4] = '{19'd0, 19'd1, 19'd31, 19'd32};
	logic [imm_w-1:0] extremes [4] = '{19'h7ffff, 19'h40000, 19'h3ffff, 19'h00001};

	datapath_top datapath_top_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.res_ready(res_ready),
		.in_ready(in_ready),
		.res_valid(res_valid),
		.res_dest(res_dest),
		.res_z(res_z)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] encode_reg(logic [4:0] op, int ra, int rb, int rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'b0};
	endfunction

	function automatic logic [31:0] encode_imm(logic [4:0] op, int ra, int rb,
			logic [imm_w-1:0] imm);
		return {op, 4'(ra), 4'(rb), imm};
	endfunction

	// Expected behavior of one word against the model state
	function automatic logic ref_exec(input logic [31:0] instr,
			input logic [31:0] regs [reg_count], inout logic [63:0] hilo,
			output logic [63:0] z, output logic wr, output logic [31:0] wr_val);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		int sh;
		logic legal;
		a = regs[instr[rb_lsb +: reg_idx_w]];
		b = regs[instr[rc_lsb +: reg_idx_w]];
		imm = 32'(instr[imm_w-1:0]);
		if (instr[imm_w-1])
			imm = imm - (32'd1 << imm_w);    // Negative 19-bit value
		sh = b % 32;
		legal = 1'b1;
		wr = 1'b1;
		res = '0;
		case (instr[opcode_lsb +: 5])
			op_add: res = a + b;
			op_sub: res = a - b;
			op_and: res = a & b;
			op_or: res = a | b;
			op_shr: res = (b >= 32) ? 32'd0 : a >> b;
			op_shl: res = (b >= 32) ? 32'd0 : a << b;
			op_ror: res = (a >> sh) | (a << (32 - sh));
			op_rol: res = (a << sh) | (a >> (32 - sh));
			op_addi: res = a + imm;
			op_andi: res = a & imm;
			op_ori: res = a | imm;
			op_neg: res = 32'd0 - a;
			op_not: res = ~a;
			op_mul: begin
				wr = 1'b0;
				hilo = {32'd0, a} * {32'd0, b};
			end
			default: begin
				legal = 1'b0;
				wr = 1'b0;
			end
		endcase
		z = (instr[opcode_lsb +: 5] == op_mul) ? hilo : {32'd0, res};
		wr_val = res;
		return legal;
	endfunction

	// Enters on a falling edge and returns on the one after acceptance
	task automatic send_word(input logic [31:0] word);
		logic [63:0] z;
		logic wr;
		logic [31:0] wr_val;
		in_valid = 1'b1;
		in_instr = word;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		if (ref_exec(word, model_regs, model_hilo, z, wr, wr_val))
			expected_q.push_back({word[ra_lsb +: reg_idx_w], z});
		if (wr)
			model_regs[word[ra_lsb +: reg_idx_w]] = wr_val;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	always @(negedge clk) begin
		case (ready_mode)
			0: res_ready = 1'b1;
			1: res_ready = ($urandom_range(0, 2) != 0);
			default: res_ready = 1'b0;
		endcase
	end

	always @(posedge clk) begin
		if (!reset && in_valid && !in_ready)
			saw_full = 1'b1;
	end

	always @(posedge clk) begin
		logic [reg_idx_w+2*data_w-1:0] exp_entry;
		if (!reset && res_valid && res_ready) begin
			if (expected_q.size() == 0) begin
				errors++;
				$display("Unexpected result at %0t for register %0d", $time, res_dest);
			end else begin
				exp_entry = expected_q.pop_front();
				if (res_dest !== exp_entry[2*data_w +: reg_idx_w]) begin
					errors++;
					$display("mismatch at %0t: res_dest got %0d expected %0d", $time,
						res_dest, exp_entry[2*data_w +: reg_idx_w]);
				end
				if (res_z !== exp_entry[2*data_w-1:0]) begin
					errors++;
					$display("mismatch at %0t: res_z got %h expected %h", $time,
						res_z, exp_entry[2*data_w-1:0]);
				end
			end
		end
	end

	initial begin
		logic [imm_w-1:0] opa;
		logic [imm_w-1:0] opb;
		int rx;
		void'($urandom(32'h7f39));
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		res_ready = 1'b0;
		ready_mode = 0;
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		model_hilo = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (res_valid !== 1'b0) begin
			errors++;
			$display("res_valid is not low after reset");
		end
		if (in_ready !== 1'b1) begin
			errors++;
			$display("in_ready is not high after reset");
		end
		send_word(encode_reg(op_add, 3, 1, 2));    // Never-written sources
		send_word(encode_imm(op_addi, 1, 0, 19'd7));
		send_word(encode_imm(op_addi, 2, 0, 19'h7fffd));
		send_word(encode_reg(op_add, 3, 1, 2));
		send_word(encode_reg(op_sub, 4, 3, 1));
		send_word(encode_reg(op_and, 5, 4, 2));
		send_word(encode_reg(op_or, 6, 5, 1));
		send_word(encode_reg(op_neg, 7, 6, 0));
		send_word(encode_reg(op_not, 1, 7, 0));
		ready_mode = 1;
		for (int i = 0; i < 60; i++)
			send_word(encode_reg(reg_ops[$urandom_range(0, 5)], $urandom_range(1, 7),
				$urandom_range(0, 7), $urandom_range(0, 7)));
		for (int i = 0; i < 12; i++) begin
			opa = 19'($urandom());
			opa[imm_w-1] = i[0];    // Alternate the sign bit
			send_word(encode_imm(imm_ops[i % 3], $urandom_range(1, 7),
				$urandom_range(1, 7), opa));
		end
		for (int s = 0; s < 4; s++) begin
			send_word(encode_imm(op_addi, 10, 0, 19'($urandom())));
			for (int k = 0; k < 9; k++) begin
				opa = (k < 4) ? shift_amounts[k] : 19'($urandom());
				send_word(encode_imm(op_addi, 9, 0, opa));
				send_word(encode_reg(shift_ops[s], $urandom_range(1, 7), 10, 9));
			end
		end
		for (int i = 0; i < 8; i++) begin
			opa = (i < 4) ? extremes[i] : 19'($urandom());
			opb = (i < 4) ? extremes[(i * 3) % 4] : 19'($urandom());
			rx = $urandom_range(1, 15);
			send_word(encode_imm(op_addi, 12, 0, opa));
			send_word(encode_imm(op_addi, 13, 0, opb));
			send_word(encode_reg(op_mul, rx, 12, 13));
			send_word(encode_reg(op_or, 11, rx, rx));    // ra must be untouched
		end
		ready_mode = 2;
		saw_full = 1'b0;
		fork
			for (int i = 0; i < 40; i++) begin
				logic [4:0] op;
				logic [31:0] bits;
				bits = $urandom();
				if (i % 8 == 0)
					op = 5'b10001;    // Divide encoding
				else if (i % 8 == 4)
					op = 5'($urandom_range(20, 31));
				else
					op = all_ops[$urandom_range(0, 13)];
				send_word({op, bits[26:0]});
			end
			begin
				repeat (60) @(negedge clk);
				ready_mode = 1;
			end
		join
		if (!saw_full) begin
			errors++;
			$display("in_ready never dropped while results were held back");
		end
		ready_mode = 0;
		for (int i = 0; i < 200 && expected_q.size() != 0; i++)
			@(posedge clk);
		repeat (20) @(posedge clk);
		if (expected_q.size() != 0) begin
			errors += expected_q.size();
			$display("%0d expected results never arrived", expected_q.size());
		end
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("Run hung, watchdog expired after %0d cycles", limit_cycles);
		$display("Errors: %0d", errors + 1);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog/datapath_top.sv
`timescale 1ns/1ps

module datapath_top import isa_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic [data_w-1:0] in_instr,
	input  logic res_ready,
	output logic in_ready,
	output logic res_valid,
	output logic [reg_idx_w-1:0] res_dest,
	output logic [2*data_w-1:0] res_z
);

	logic push;
	decoded_op_t push_op;
	logic credit_return;
	logic head_valid;
	decoded_op_t head_op;
	logic pop;

	op_decoder op_decoder_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.credit_return(credit_return),
		.in_ready(in_ready),
		.push(push),
		.push_op(push_op)
	);

	op_queue op_queue_inst (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_op(push_op),
		.pop(pop),
		.head_valid(head_valid),
		.head_op(head_op),
		.credit_return(credit_return)
	);

	execute_unit execute_unit_inst (
		.clk(clk),
		.reset(reset),
		.head_valid(head_valid),
		.head_op(head_op),
		.res_ready(res_ready),
		.pop(pop),
		.res_valid(res_valid),
		.res_dest(res_dest),
		.res_z(res_z)
	);

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import isa_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic head_valid,
	input  decoded_op_t head_op,
	input  logic res_ready,
	output logic pop,
	output logic res_valid,
	output logic [reg_idx_w-1:0] res_dest,
	output logic [2*data_w-1:0] res_z
);

	logic [data_w-1:0] rd_a;
	logic [data_w-1:0] rd_b;
	logic [data_w-1:0] operand_b;
	logic [2*data_w-1:0] alu_z;
	logic is_mul;
	logic [data_w-1:0] hi;
	logic [data_w-1:0] lo;
	logic [data_w-1:0] z_lo;
	logic res_mul;

	// Slot free now or emptied at this edge
	assign pop = head_valid & (~res_valid | res_ready);
	assign is_mul = (head_op.opcode == op_mul);
	assign operand_b = head_op.is_imm ? head_op.imm : rd_b;

	register_file register_file_inst (
		.clk(clk),
		.reset(reset),
		.rd_a_idx(head_op.src_a),
		.rd_b_idx(head_op.src_b),
		.wr_en(pop & ~is_mul),
		.wr_idx(head_op.dest),
		.wr_data(alu_z[data_w-1:0]),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	alu alu_inst (
		.op(head_op.opcode),
		.a(rd_a),
		.b(operand_b),
		.z(alu_z)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			hi <= '0;
			lo <= '0;
		end else begin
			if (pop)
				res_valid <= 1'b1;
			else if (res_ready)
				res_valid <= 1'b0;
			if (pop && is_mul)
				{hi, lo} <= alu_z;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			res_dest <= head_op.dest;
			res_mul <= is_mul;
			z_lo <= alu_z[data_w-1:0];
		end
	end

	// For mul the Z pair is HI:LO, written at the same edge
	assign res_z = res_mul ? {hi, lo} : {{data_w{1'b0}}, z_lo};

endmodule

// File: verilog/op_queue.sv
`timescale 1ns/1ps

module op_queue import isa_pkg::*, flow_pkg::*; #(
	parameter int depth = queue_depth
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  decoded_op_t push_op,
	input  logic pop,
	output logic head_valid,
	output decoded_op_t head_op,
	output logic credit_return
);

	decoded_op_t slots [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [credit_w-1:0] count;
	logic do_pop;

	assign head_valid = (count != '0);
	assign head_op = slots[rd_ptr];
	assign do_pop = pop & head_valid;
	assign credit_return = do_pop;      // Each pop frees a slot and returns its credit

	// Decoder credits keep a slot free for every push
	always_ff @(posedge clk) begin
		if (push)
			slots[wr_ptr] <= push_op;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/op_decoder.sv
`timescale 1ns/1ps

module op_decoder import isa_pkg::*, flow_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic [data_w-1:0] in_instr,
	input  logic credit_return,
	output logic in_ready,
	output logic push,
	output decoded_op_t push_op
);

	logic [credit_w-1:0] credits;
	opcode_t opcode;
	logic legal;
	logic spend;

	assign opcode = opcode_t'(in_instr[opcode_lsb +: opcode_w]);
	assign in_ready = (credits != '0);

	always_comb begin
		case (opcode)
			op_add, op_sub, op_and, op_or,
			op_shr, op_shl, op_ror, op_rol,
			op_addi, op_andi, op_ori,
			op_mul, op_neg, op_not: legal = 1'b1;
			default: legal = 1'b0;     // Divide and unused codes end here
		endcase
	end

	assign spend = in_valid & in_ready & legal;

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= credit_w'(queue_depth);
			push <= 1'b0;
		end else begin
			push <= spend;
			case ({spend, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (spend) begin
			push_op.opcode <= opcode;
			push_op.dest <= in_instr[ra_lsb +: reg_idx_w];
			push_op.src_a <= in_instr[rb_lsb +: reg_idx_w];
			push_op.src_b <= in_instr[rc_lsb +: reg_idx_w];
			push_op.is_imm <= (opcode == op_addi) || (opcode == op_andi) || (opcode == op_ori);
			push_op.imm <= {{(data_w-imm_w){in_instr[imm_w-1]}}, in_instr[imm_w-1:0]};
		end
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import isa_pkg::*; (
	input  opcode_t op,
	input  logic [data_w-1:0] a,
	input  logic [data_w-1:0] b,
	output logic [2*data_w-1:0] z
);

	logic [data_w-1:0] result;
	logic [2*data_w-1:0] doubled;
	logic [2*data_w-1:0] product;
	logic [sh_w-1:0] amount;
	logic too_far;

	assign amount = b[sh_w-1:0];
	assign too_far = |b[data_w-1:sh_w];    // Shift of 32 or more
	assign doubled = {a, a};
	assign product = {{data_w{1'b0}}, a} * {{data_w{1'b0}}, b};

	always_comb begin
		result = '0;
		case (op)
			op_add, op_addi: result = a + b;
			op_sub: result = a - b;
			op_and, op_andi: result = a & b;
			op_or, op_ori: result = a | b;
			op_shr: result = too_far ? '0 : a >> amount;
			op_shl: result = too_far ? '0 : a << amount;
			op_ror: begin
				result = data_w'(doubled >> amount);
			end
			op_rol: begin
				// Upper copy after shifting left carries the wrapped bits
				result = doubled[2*data_w-1-amount -: data_w];
			end
			op_neg: result = -a;
			op_not: result = ~a;
			default: result = '0;
		endcase
	end

	always_comb begin
		if (op == op_mul)
			z = product;
		else
			z = {{data_w{1'b0}}, result};
	end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file import isa_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [reg_idx_w-1:0] rd_a_idx,
	input  logic [reg_idx_w-1:0] rd_b_idx,
	input  logic wr_en,
	input  logic [reg_idx_w-1:0] wr_idx,
	input  logic [data_w-1:0] wr_data,
	output logic [data_w-1:0] rd_a,
	output logic [data_w-1:0] rd_b
);

	logic [data_w-1:0] regs [reg_count];

	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

// File: verilog/flow_pkg.sv
package flow_pkg;

	// Queue slots, also the decoder's starting credit count
	localparam int queue_depth = 4;

	localparam int ptr_w = 2;

	// Must be able to hold queue_depth itself
	localparam int credit_w = 3;

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

	localparam int data_w = 32;
	localparam int reg_count = 16;
	localparam int reg_idx_w = 4;
	localparam int imm_w = 19;
	localparam int opcode_w = 5;
	localparam int sh_w = 5;        // Shift amount bits used by rotates

	// Instruction field positions
	localparam int opcode_lsb = 27;
	localparam int ra_lsb = 23;
	localparam int rb_lsb = 19;
	localparam int rc_lsb = 15;

	typedef enum logic [opcode_w-1:0] {
		op_add  = 5'b00101,
		op_sub  = 5'b00110,
		op_and  = 5'b00111,
		op_or   = 5'b01000,
		op_shr  = 5'b01001,
		op_shl  = 5'b01010,
		op_ror  = 5'b01011,
		op_rol  = 5'b01100,
		op_addi = 5'b01101,
		op_andi = 5'b01110,
		op_ori  = 5'b01111,
		op_mul  = 5'b10000,
		op_neg  = 5'b10010,
		op_not  = 5'b10011
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [reg_idx_w-1:0] dest;     // ra
		logic [reg_idx_w-1:0] src_a;    // rb
		logic [reg_idx_w-1:0] src_b;    // rc
		logic is_imm;
		logic [data_w-1:0] imm;         // Already sign-extended
	} decoded_op_t;

endpackage
